/* hdl/audio_pkg.sv */
//================================================
// serial audio format constants
//   sample width, slot and frame lengths in BCLK
//   BCLK divider setting in CLK cycles
//================================================

package audio_pkg;

	// one DAC sample, sent MSB first
	localparam int sample_w = 24;

	// BCLK periods per channel slot
	localparam int slot_bits = 32;

	// left slot plus right slot
	localparam int frame_bits = 64;

	// CLK cycles per BCLK half period
	// 50 MHz / (2 * 2) gives 12.5 MHz BCLK
	localparam int bclk_half = 2;

endpackage

/* hdl/wb_pkg.sv */
//================================================
// shared Wishbone bus definitions
//   data and address widths, sample RAM depth
//   master indices on the arbiter
//================================================

package wb_pkg;

	// bus data width, samples sit in the low bits
	localparam int data_w = 32;

	// sample words, even = left, odd = right
	localparam int ram_depth = 64;

	// word address width
	localparam int adr_w = 6;

	// arbiter master slots
	localparam int mst_host  = 0;
	localparam int mst_fetch = 1;   // wins when both request

endpackage

/* hdl/wb_arbiter.sv */
//================================================
// two-master Wishbone classic arbiter
//   fixed priority, fetcher over host
//   grant taken only on an idle bus, held while
//   the owner keeps cyc high
//================================================

module wb_arbiter (
	input  logic                      CLK,
	input  logic                      RST,
	// master 0, host
	input  logic                      m0_cyc,
	input  logic                      m0_stb,
	input  logic                      m0_we,
	input  logic [wb_pkg::adr_w-1:0]  m0_adr,
	input  logic [wb_pkg::data_w-1:0] m0_dat_w,
	output logic [wb_pkg::data_w-1:0] m0_dat_r,
	output logic                      m0_ack,
	// master 1, playback fetcher
	input  logic                      m1_cyc,
	input  logic                      m1_stb,
	input  logic                      m1_we,
	input  logic [wb_pkg::adr_w-1:0]  m1_adr,
	input  logic [wb_pkg::data_w-1:0] m1_dat_w,
	output logic [wb_pkg::data_w-1:0] m1_dat_r,
	output logic                      m1_ack,
	// shared slave bus
	output logic                      s_cyc,
	output logic                      s_stb,
	output logic                      s_we,
	output logic [wb_pkg::adr_w-1:0]  s_adr,
	output logic [wb_pkg::data_w-1:0] s_dat_w,
	input  logic [wb_pkg::data_w-1:0] s_dat_r,
	input  logic                      s_ack
);

	logic busy;         // bus owned by someone
	logic owner;        // master index of current owner
	logic gnt_host;
	logic gnt_fetch;

	assign gnt_host  = busy && (owner == 1'(wb_pkg::mst_host));
	assign gnt_fetch = busy && (owner == 1'(wb_pkg::mst_fetch));

	//================================================
	// grant register
	//================================================
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			busy  <= 1'b0;
			owner <= 1'(wb_pkg::mst_host);
		end else if (!busy) begin
			if (m1_cyc) begin
				busy  <= 1'b1;
				owner <= 1'(wb_pkg::mst_fetch);
			end else if (m0_cyc) begin
				busy  <= 1'b1;
				owner <= 1'(wb_pkg::mst_host);
			end
		end else if (gnt_fetch ? !m1_cyc : !m0_cyc) begin
			busy <= 1'b0;   // owner let go of the bus
		end
	end

	//================================================
	// request mux and return path
	//================================================
	always_comb begin
		s_cyc   = 1'b0;
		s_stb   = 1'b0;
		s_we    = 1'b0;
		s_adr   = '0;
		s_dat_w = '0;
		if (gnt_fetch) begin
			s_cyc   = m1_cyc;
			s_stb   = m1_stb;
			s_we    = m1_we;
			s_adr   = m1_adr;
			s_dat_w = m1_dat_w;
		end else if (gnt_host) begin
			s_cyc   = m0_cyc;
			s_stb   = m0_stb;
			s_we    = m0_we;
			s_adr   = m0_adr;
			s_dat_w = m0_dat_w;
		end
	end

	// a waiting master sees no ack
	assign m0_ack   = s_ack && gnt_host;
	assign m1_ack   = s_ack && gnt_fetch;
	assign m0_dat_r = gnt_host ? s_dat_r : '0;
	assign m1_dat_r = gnt_fetch ? s_dat_r : '0;

endmodule

/* hdl/sample_ram.sv */
//================================================
// sample memory, Wishbone classic slave
//   64 x 24 bit words, zero-extended reads
//   registered single-cycle ack
//================================================

module sample_ram (
	input  logic                      CLK,
	input  logic                      RST,
	input  logic                      cyc,
	input  logic                      stb,
	input  logic                      we,
	input  logic [wb_pkg::adr_w-1:0]  adr,
	input  logic [wb_pkg::data_w-1:0] dat_w,
	output logic [wb_pkg::data_w-1:0] dat_r,
	output logic                      ack
);

	logic [audio_pkg::sample_w-1:0] mem [wb_pkg::ram_depth];
	logic                           req;

	// master still holds stb while it sees ack, so skip that cycle
	assign req = cyc && stb && !ack;

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST)
			ack <= 1'b0;
		else
			ack <= req;
	end

	always_ff @(posedge CLK) begin
		if (req && we)
			mem[adr] <= dat_w[audio_pkg::sample_w-1:0];   // upper bits dropped
		dat_r <= {{(wb_pkg::data_w - audio_pkg::sample_w){1'b0}}, mem[adr]};
	end

endmodule

/* hdl/sample_fetch.sv */
//================================================
// playback fetcher, Wishbone read-only master
//   walks the RAM in stereo pairs, left then right
//   holds one pair for the serializer
//================================================

module sample_fetch (
	input  logic                           CLK,
	input  logic                           RST,
	input  logic                           play_en,
	// bus master side
	output logic                           cyc,
	output logic                           stb,
	output logic                           we,
	output logic [wb_pkg::adr_w-1:0]       adr,
	output logic [wb_pkg::data_w-1:0]      dat_w,
	input  logic [wb_pkg::data_w-1:0]      dat_r,
	input  logic                           ack,
	// serializer side
	input  logic                           frame_load,
	output logic                           pair_valid,
	output logic [audio_pkg::sample_w-1:0] left_sample,
	output logic [audio_pkg::sample_w-1:0] right_sample
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RD_LEFT,
		ST_RD_RIGHT
	} state_t;

	state_t                   state;
	logic [wb_pkg::adr_w-2:0] pair_idx;   // wraps after the last pair

	// read only
	assign we    = 1'b0;
	assign dat_w = '0;

	//================================================
	// fetch FSM
	//================================================
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			state      <= ST_IDLE;
			pair_idx   <= '0;
			cyc        <= 1'b0;
			stb        <= 1'b0;
			adr        <= '0;
			pair_valid <= 1'b0;
		end else begin
			if (frame_load)
				pair_valid <= 1'b0;   // serializer took the pair
			case (state)
				ST_IDLE: begin
					if (!play_en) begin
						pair_idx   <= '0;     // next play starts at pair 0
						pair_valid <= 1'b0;
					end else if (!pair_valid) begin
						cyc   <= 1'b1;
						stb   <= 1'b1;
						adr   <= {pair_idx, 1'b0};
						state <= ST_RD_LEFT;
					end
				end
				ST_RD_LEFT: begin
					if (ack) begin
						adr   <= {pair_idx, 1'b1};   // keep cyc, move to right word
						state <= ST_RD_RIGHT;
					end
				end
				ST_RD_RIGHT: begin
					if (ack) begin
						cyc        <= 1'b0;
						stb        <= 1'b0;
						pair_valid <= play_en;   // stopped mid-fetch gives no pair
						pair_idx   <= pair_idx + 1'b1;
						state      <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// sample payload
	always_ff @(posedge CLK) begin
		if (ack && state == ST_RD_LEFT)
			left_sample <= dat_r[audio_pkg::sample_w-1:0];
		if (ack && state == ST_RD_RIGHT)
			right_sample <= dat_r[audio_pkg::sample_w-1:0];
	end

endmodule

/* hdl/i2s_dac_tx.sv */
//================================================
// I2S transmitter for a WM8731-class DAC
//   BCLK divider with CLK-domain edge strobes
//   64-slot frame counter and DACLRC
//   24-bit MSB-first shift-out, frame load
//   and underrun pulse
//================================================

module i2s_dac_tx (
	input  logic                           CLK,
	input  logic                           RST,
	input  logic                           play_en,
	input  logic                           pair_valid,
	input  logic [audio_pkg::sample_w-1:0] left_sample,
	input  logic [audio_pkg::sample_w-1:0] right_sample,
	output logic                           frame_load,
	output logic                           underrun,
	output logic                           BCLK,
	output logic                           DACLRC,
	output logic                           DACDAT
);

	localparam int cnt_w  = $clog2(audio_pkg::bclk_half);
	localparam int slot_w = $clog2(audio_pkg::frame_bits);

	logic [cnt_w-1:0]               div_cnt;
	logic                           bclk_fall;   // BCLK falls at this edge
	logic                           bclk_rise;
	logic [slot_w-1:0]              slot;
	logic [slot_w-1:0]              slot_nxt;
	logic                           frame_start;
	logic                           data_slot;   // slot_nxt carries a data bit
	logic [audio_pkg::sample_w-1:0] left_sh;
	logic [audio_pkg::sample_w-1:0] right_sh;
	logic [audio_pkg::sample_w-1:0] shreg;

	//================================================
	// BCLK divider
	//================================================
	assign bclk_fall = (div_cnt == cnt_w'(audio_pkg::bclk_half - 1)) && BCLK;
	assign bclk_rise = (div_cnt == cnt_w'(audio_pkg::bclk_half - 1)) && !BCLK;

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			div_cnt <= '0;
			BCLK    <= 1'b0;
		end else if (div_cnt == cnt_w'(audio_pkg::bclk_half - 1)) begin
			div_cnt <= '0;
			BCLK    <= !BCLK;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	//================================================
	// slot counter and framing
	//================================================
	assign slot_nxt    = (slot == slot_w'(audio_pkg::frame_bits - 1)) ? '0 : slot + 1'b1;
	assign frame_start = bclk_fall && (slot_nxt == '0);
	assign data_slot   =
		(slot_nxt >= slot_w'(1) && slot_nxt <= slot_w'(audio_pkg::sample_w)) ||
		(slot_nxt >= slot_w'(audio_pkg::slot_bits + 1) &&
		 slot_nxt <= slot_w'(audio_pkg::slot_bits + audio_pkg::sample_w));

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			slot       <= '0;
			DACLRC     <= 1'b0;
			frame_load <= 1'b0;
			underrun   <= 1'b0;
		end else begin
			frame_load <= frame_start && pair_valid;
			underrun   <= frame_start && !pair_valid && play_en;
			if (bclk_fall) begin
				slot   <= slot_nxt;
				DACLRC <= (slot_nxt >= slot_w'(audio_pkg::slot_bits));   // right half
			end
		end
	end

	//================================================
	// shadow samples and shift-out
	//================================================
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			left_sh  <= '0;
			right_sh <= '0;
			shreg    <= '0;
			DACDAT   <= 1'b0;
		end else begin
			if (frame_start) begin
				left_sh  <= pair_valid ? left_sample : '0;   // silence on a missing pair
				right_sh <= pair_valid ? right_sample : '0;
			end
			// load mid-slot, shadows are settled by then
			if (bclk_rise && slot == '0)
				shreg <= left_sh;
			else if (bclk_rise && slot == slot_w'(audio_pkg::slot_bits))
				shreg <= right_sh;
			else if (bclk_fall && data_slot)
				shreg <= {shreg[audio_pkg::sample_w-2:0], 1'b0};
			if (bclk_fall)
				DACDAT <= data_slot ? shreg[audio_pkg::sample_w-1] : 1'b0;
		end
	end

endmodule

/* hdl/audio_out_top.sv */
//================================================
// audio playback top level
//   host port and fetcher share the sample RAM
//   through the arbiter, serializer drives the DAC
//================================================

module audio_out_top (
	input  logic                      CLK,
	input  logic                      RST,
	input  logic                      play_en,
	// host Wishbone port
	input  logic                      host_cyc,
	input  logic                      host_stb,
	input  logic                      host_we,
	input  logic [wb_pkg::adr_w-1:0]  host_adr,
	input  logic [wb_pkg::data_w-1:0] host_dat_w,
	output logic [wb_pkg::data_w-1:0] host_dat_r,
	output logic                      host_ack,
	// DAC side
	output logic                      underrun,
	output logic                      BCLK,
	output logic                      DACLRC,
	output logic                      DACDAT
);

	// fetcher master
	logic                           fetch_cyc;
	logic                           fetch_stb;
	logic                           fetch_we;
	logic [wb_pkg::adr_w-1:0]       fetch_adr;
	logic [wb_pkg::data_w-1:0]      fetch_dat_w;
	logic [wb_pkg::data_w-1:0]      fetch_dat_r;
	logic                           fetch_ack;
	// shared RAM bus
	logic                           ram_cyc;
	logic                           ram_stb;
	logic                           ram_we;
	logic [wb_pkg::adr_w-1:0]       ram_adr;
	logic [wb_pkg::data_w-1:0]      ram_dat_w;
	logic [wb_pkg::data_w-1:0]      ram_dat_r;
	logic                           ram_ack;
	// fetcher to serializer
	logic                           pair_valid;
	logic [audio_pkg::sample_w-1:0] left_sample;
	logic [audio_pkg::sample_w-1:0] right_sample;
	logic                           frame_load;

	wb_arbiter arb_i (
		.CLK      (CLK),
		.RST      (RST),
		.m0_cyc   (host_cyc),
		.m0_stb   (host_stb),
		.m0_we    (host_we),
		.m0_adr   (host_adr),
		.m0_dat_w (host_dat_w),
		.m0_dat_r (host_dat_r),
		.m0_ack   (host_ack),
		.m1_cyc   (fetch_cyc),
		.m1_stb   (fetch_stb),
		.m1_we    (fetch_we),
		.m1_adr   (fetch_adr),
		.m1_dat_w (fetch_dat_w),
		.m1_dat_r (fetch_dat_r),
		.m1_ack   (fetch_ack),
		.s_cyc    (ram_cyc),
		.s_stb    (ram_stb),
		.s_we     (ram_we),
		.s_adr    (ram_adr),
		.s_dat_w  (ram_dat_w),
		.s_dat_r  (ram_dat_r),
		.s_ack    (ram_ack)
	);

	sample_ram ram_i (
		.CLK   (CLK),
		.RST   (RST),
		.cyc   (ram_cyc),
		.stb   (ram_stb),
		.we    (ram_we),
		.adr   (ram_adr),
		.dat_w (ram_dat_w),
		.dat_r (ram_dat_r),
		.ack   (ram_ack)
	);

	sample_fetch fetch_i (
		.CLK          (CLK),
		.RST          (RST),
		.play_en      (play_en),
		.cyc          (fetch_cyc),
		.stb          (fetch_stb),
		.we           (fetch_we),
		.adr          (fetch_adr),
		.dat_w        (fetch_dat_w),
		.dat_r        (fetch_dat_r),
		.ack          (fetch_ack),
		.frame_load   (frame_load),
		.pair_valid   (pair_valid),
		.left_sample  (left_sample),
		.right_sample (right_sample)
	);

	i2s_dac_tx tx_i (
		.CLK          (CLK),
		.RST          (RST),
		.play_en      (play_en),
		.pair_valid   (pair_valid),
		.left_sample  (left_sample),
		.right_sample (right_sample),
		.frame_load   (frame_load),
		.underrun     (underrun),
		.BCLK         (BCLK),
		.DACLRC       (DACLRC),
		.DACDAT       (DACDAT)
	);

endmodule

/* dv/audio_out_assert.sv */
//==================================================
// bound checks on the playback top level
//   Wishbone ack rules, DACLRC period
//   DACDAT quiet after each 24-bit word
//==================================================

module audio_out_assert (
	input logic CLK,
	input logic RST,
	input logic host_cyc,
	input logic host_stb,
	input logic host_ack,
	input logic fetch_cyc,
	input logic fetch_stb,
	input logic fetch_ack,
	input logic ram_cyc,
	input logic ram_stb,
	input logic ram_ack,
	input logic DACLRC,
	input logic DACDAT
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int slot_clk = 2 * audio_pkg::bclk_half;   // CLK per BCLK

	logic       lrc_q;
	logic       armed;     // one DACLRC edge seen
	logic [7:0] lrc_cnt;   // CLK cycles since last DACLRC edge
	logic       lrc_edge;
	logic [7:0] pos;

	assign lrc_edge = DACLRC != lrc_q;
	assign pos      = lrc_edge ? 8'd0 : lrc_cnt + 8'd1;

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			lrc_q   <= 1'b0;
			armed   <= 1'b0;
			lrc_cnt <= '0;
		end else begin
			lrc_q   <= DACLRC;
			lrc_cnt <= pos;
			if (lrc_edge)
				armed <= 1'b1;
		end
	end

	a_host_ack: assert property (@(posedge CLK) disable iff (!RST)
		host_ack |-> host_cyc && host_stb) else $error("host ack outside a request");
	a_fetch_ack: assert property (@(posedge CLK) disable iff (!RST)
		fetch_ack |-> fetch_cyc && fetch_stb) else $error("fetch ack outside a request");
	a_ram_ack: assert property (@(posedge CLK) disable iff (!RST)
		ram_ack |-> ram_cyc && ram_stb) else $error("RAM ack outside a request");
	// every RAM ack lands on exactly one master, never lost and never doubled
	a_one_ack: assert property (@(posedge CLK) disable iff (!RST)
		ram_ack |-> $onehot({host_ack, fetch_ack}))
		else $error("RAM ack not routed to exactly one master");
	a_lrc_period: assert property (@(posedge CLK) disable iff (!RST)
		lrc_edge && armed |-> lrc_cnt == 8'(audio_pkg::slot_bits * slot_clk - 1))
		else $error("DACLRC half period is not 32 BCLK");
	a_dat_quiet: assert property (@(posedge CLK) disable iff (!RST)
		armed && pos >= 8'((audio_pkg::sample_w + 1) * slot_clk) |-> !DACDAT)
		else $error("DACDAT high after the sample bits");

endmodule

bind audio_out_top audio_out_assert assert_i (
	.CLK       (CLK),
	.RST       (RST),
	.host_cyc  (host_cyc),
	.host_stb  (host_stb),
	.host_ack  (host_ack),
	.fetch_cyc (fetch_cyc),
	.fetch_stb (fetch_stb),
	.fetch_ack (fetch_ack),
	.ram_cyc   (ram_cyc),
	.ram_stb   (ram_stb),
	.ram_ack   (ram_ack),
	.DACLRC    (DACLRC),
	.DACDAT    (DACDAT)
);

/* dv/tb_audio_out.sv */
//==================================================
// testbench for the audio playback top level
//   clock, reset, Wishbone host tasks
//   I2S receiver model, reference function
//   frame checker and watchdog
//==================================================

module tb_audio_out;
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic [31:0] l;
		logic [31:0] r;
		logic [7:0]  lc;   // BCLK periods in left slot
		logic [7:0]  rc;
		logic        ur;   // underrun seen at frame start
	} frame_t;

	// about 65 frames of traffic plus margin
	localparam int frame_ns = 256 * 10;
	localparam int limit_ns = 90 * frame_ns + 20000;

	logic        CLK;
	logic        RST;
	logic        play_en;
	logic        host_cyc;
	logic        host_stb;
	logic        host_we;
	logic [5:0]  host_adr;
	logic [31:0] host_dat_w;
	logic [31:0] host_dat_r;
	logic        host_ack;
	logic        underrun;
	logic        BCLK;
	logic        DACLRC;
	logic        DACDAT;

	logic [31:0] model [64];
	frame_t      frames [$];
	integer      seed = 32'h9ff8_91d8;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;

	audio_out_top dut_i (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = !CLK;
	end

	initial begin
		#(limit_ns);
		$display("watchdog expired, DUT stopped producing frames");
		$display("Test FAILED");
		$finish;
	end

	//==================================================
	// I2S receiver, everything sampled on CLK
	//==================================================
	logic        bclk_q = 1'b0;
	logic        lrc_q = 1'b0;
	logic        synced = 1'b0;
	logic        ur_seen = 1'b0;
	logic [31:0] sh = '0;
	int          cnt = 0;
	frame_t      cur;

	always @(posedge CLK) begin
		if (underrun)
			ur_seen = 1'b1;
		if (BCLK && !bclk_q) begin
			if (DACLRC != lrc_q) begin
				if (!DACLRC) begin
					if (synced) begin   // right slot done, frame complete
						cur.r  = sh;
						cur.rc = 8'(cnt);
						frames.push_back(cur);
					end
					synced  = 1'b1;
					cur.ur  = ur_seen;
					ur_seen = 1'b0;
				end else begin
					cur.l  = sh;
					cur.lc = 8'(cnt);
				end
				sh  = {31'b0, DACDAT};
				cnt = 1;
			end else begin
				sh  = {sh[30:0], DACDAT};
				cnt = cnt + 1;
			end
			lrc_q = DACLRC;
		end
		bclk_q = BCLK;
	end

	//==================================================
	// reference model
	//==================================================
	function automatic logic [47:0] expected_pair(input int n);
		int k;
		k = n % 32;
		return {model[2*k][23:0], model[2*k+1][23:0]};
	endfunction

	// slot 0 empty, 24 data bits, then zeros
	function automatic logic [31:0] slot_word(input logic [23:0] s);
		return {1'b0, s, 7'b0};
	endfunction

	task automatic report_fail(input string msg);
		errors++;
		$display("[FAIL] %0d ns: %s", $time, msg);
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		if (errors == err_before)
			$display("test %s: passed", name);
		else
			$display("test %s: failed with %0d errors", name, errors - err_before);
	endtask

	//==================================================
	// host bus tasks
	//==================================================
	task automatic wb_write(input logic [5:0] adr, input logic [31:0] dat);
		@(posedge CLK);
		host_cyc   <= 1'b1;
		host_stb   <= 1'b1;
		host_we    <= 1'b1;
		host_adr   <= adr;
		host_dat_w <= dat;
		do @(posedge CLK); while (!host_ack);
		host_cyc <= 1'b0;
		host_stb <= 1'b0;
		host_we  <= 1'b0;
	endtask

	task automatic wb_read(input logic [5:0] adr, output logic [31:0] dat);
		@(posedge CLK);
		host_cyc <= 1'b1;
		host_stb <= 1'b1;
		host_we  <= 1'b0;
		host_adr <= adr;
		do @(posedge CLK); while (!host_ack);
		dat = host_dat_r;
		host_cyc <= 1'b0;
		host_stb <= 1'b0;
	endtask

	task automatic pop_frame(output frame_t f);
		while (frames.size() == 0)
			@(posedge CLK);
		f = frames.pop_front();
	endtask

	// switch play_en right after a received frame boundary,
	// then drop the frame the DUT had already started
	task automatic set_play_en(input logic en);
		frame_t f;
		@(negedge CLK);
		frames.delete();
		pop_frame(f);
		@(posedge CLK);
		play_en <= en;
		pop_frame(f);
	endtask

	task automatic check_framing(input frame_t f);
		checks++;
		assert (f.lc == 8'd32 && f.rc == 8'd32)
		else report_fail($sformatf("slot lengths %0d/%0d BCLK", f.lc, f.rc));
	endtask

	// count valid frames in sequence, leading silent frames need underrun
	task automatic check_playback(input int count, inout int n, inout bit started);
		frame_t      f;
		logic [47:0] e;
		int          lead;
		lead = 0;
		while (count > 0) begin
			pop_frame(f);
			check_framing(f);
			checks++;
			if (!started && f.l == '0 && f.r == '0) begin
				lead++;
				assert (f.ur && lead < 4)
				else report_fail("silent lead frame without underrun or too many");
			end else begin
				started = 1'b1;
				e       = expected_pair(n);
				assert (f.l == slot_word(e[47:24]) && f.r == slot_word(e[23:0]) && !f.ur)
				else report_fail($sformatf("pair %0d got %h/%h ur=%b, expected %h/%h",
					n, f.l, f.r, f.ur, slot_word(e[47:24]), slot_word(e[23:0])));
				n++;
				count--;
			end
		end
	endtask

	//==================================================
	// test sequence
	//==================================================
	initial begin
		logic [31:0] rd;
		logic [5:0]  a;
		frame_t      f;
		int          e0;
		int          n;
		bit          started;

		RST        = 1'b0;
		play_en    = 1'b0;
		host_cyc   = 1'b0;
		host_stb   = 1'b0;
		host_we    = 1'b0;
		host_adr   = '0;
		host_dat_w = '0;
		for (int i = 0; i < 64; i++)
			model[i] = $random(seed);

		// reset
		e0 = errors;
		repeat (5) begin
			@(posedge CLK);
			checks++;
			assert (!host_ack && !BCLK && !DACLRC && !DACDAT && !underrun)
			else report_fail("outputs not low during reset");
		end
		RST <= 1'b1;
		@(posedge CLK);
		checks++;
		assert (!host_ack && !BCLK && !DACLRC && !DACDAT && !underrun)
		else report_fail("outputs not low right after reset");
		end_test("reset", e0);

		// host write and read-back, upper byte reads as zero
		e0 = errors;
		for (int i = 0; i < 64; i++)
			wb_write(6'(i), model[i]);
		for (int i = 0; i < 64; i++) begin
			wb_read(6'(i), rd);
			checks++;
			assert (rd == {8'h00, model[i][23:0]})
			else report_fail($sformatf("adr %0d read %h", i, rd));
		end
		end_test("write_read", e0);

		// playback across the wrap at pair 32
		e0 = errors;
		n       = 0;
		started = 1'b0;
		set_play_en(1'b1);
		check_playback(42, n, started);
		end_test("playback", e0);

		// host reads while the fetcher runs
		e0 = errors;
		while (frames.size() < 8) begin
			a = 6'($random(seed));
			wb_read(a, rd);
			checks++;
			assert (rd == {8'h00, model[a][23:0]})
			else report_fail($sformatf("contention adr %0d read %h", a, rd));
		end
		check_playback(8, n, started);
		end_test("contention", e0);

		// stop gives silence, restart begins at pair 0
		e0 = errors;
		set_play_en(1'b0);
		repeat (3) begin
			pop_frame(f);
			check_framing(f);
			checks++;
			assert (f.l == '0 && f.r == '0 && !f.ur)
			else report_fail($sformatf("stopped frame %h/%h ur=%b", f.l, f.r, f.ur));
		end
		n       = 0;
		started = 1'b0;
		set_play_en(1'b1);
		check_playback(5, n, started);
		end_test("stop_restart", e0);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* vlog.f */
hdl/audio_pkg.sv
hdl/wb_pkg.sv
hdl/wb_arbiter.sv
hdl/sample_ram.sv
hdl/sample_fetch.sv
hdl/i2s_dac_tx.sv
hdl/audio_out_top.sv
dv/audio_out_assert.sv
dv/tb_audio_out.sv

/* Makefile */
TOP = tb_audio_out

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f vlog.f

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Test FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" sim.log; then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
